//--- verilog/aes_pkg.sv
package aes_pkg;

  // aes-128 is fixed at ten rounds over a 128-bit block
  localparam int unsigned AES_ROUNDS = 10;
  localparam int unsigned AES_BLOCK_BITS = 128;

  // state array, byte index is row*4+col
  typedef logic [15:0][7:0] aes_state_t;

  // round FSM states
  typedef enum logic [2:0] {
    IDLE,
    INIT_KEY,
    SHIFT,
    MIX,
    FINISH
  } aes_fsm_e;

  // write-back operation for the mix/add-key stage
  typedef enum logic [1:0] {
    // raw state xor key, initial key addition
    MIX_INIT,
    // MixColumns then xor key, rounds 1 to 9
    MIX_FULL,
    // xor key only, last round
    MIX_FINAL
  } aes_mix_op_e;

  // rcon for the first expansion step
  localparam logic [7:0] aes_rcon_first = 8'h01;

  // multiply by x in GF(2^8) mod x^8+x^4+x^3+x+1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

endpackage

//--- verilog/aes_sbox.sv
`timescale 1ns/100ps

module aes_sbox import aes_pkg::*;
(
  input  logic [7:0] a,
  output logic [7:0] s
);

  // general GF(2^8) product, shift and add
  function automatic logic [7:0] gf_mul(input logic [7:0] x, input logic [7:0] y);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p = x;
    for (int i = 0; i < 8; i++)
    begin
      if (y[i])
        acc = acc ^ p;
      p = xtime(p);
    end
    return acc;
  endfunction

  logic [7:0] a2, a4, a8, a16;
  logic [7:0] n, n2, n4, n8;
  logic [7:0] n_inv;
  logic [7:0] inv;

  // frobenius powers of the input
  assign a2  = gf_mul(a, a);
  assign a4  = gf_mul(a2, a2);
  assign a8  = gf_mul(a4, a4);
  assign a16 = gf_mul(a8, a8);

  // norm a^17 lands in the GF(2^4) subfield
  assign n = gf_mul(a16, a);

  // subfield inverse as n^14 = n^8 * n^4 * n^2
  assign n2    = gf_mul(n, n);
  assign n4    = gf_mul(n2, n2);
  assign n8    = gf_mul(n4, n4);
  assign n_inv = gf_mul(gf_mul(n8, n4), n2);

  // back to the full field, a^-1 = a^16 * n^-1, zero maps to zero
  assign inv = gf_mul(a16, n_inv);

  // affine map, each bit mixes four rotated neighbours plus 0x63
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
             ^ inv[(i + 7) % 8];
    end
    s = s ^ 8'h63;
  end

endmodule

//--- verilog/aes_enc_shifter.sv
`timescale 1ns/100ps

module aes_enc_shifter import aes_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] byte_in,
  input  logic       byte_load,
  input  logic       block_start,
  input  aes_state_t state_in,
  input  logic       state_wr,
  input  logic       shift_en,
  output aes_state_t state,
  output aes_state_t shift_out
);

  // byte slot for the serial load
  logic [3:0] slot;

  // stream byte k goes to row k mod 4, col k div 4
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      state <= '0;
    else if (byte_load)
      state[{slot[1:0], slot[3:2]}] <= byte_in;
    else if (state_wr)
      state <= state_in;
  end

  // slot counter, wraps after 16 bytes
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      slot <= 4'd0;
    else if (block_start)
      slot <= 4'd0;
    else if (byte_load)
      slot <= slot + 4'd1;
  end

  // ShiftRows, row r rotated left by r
  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      for (int r = 0; r < 4; r++)
      begin
        for (int c = 0; c < 4; c++)
        begin
          shift_out[r * 4 + c] <= state[r * 4 + ((c + r) % 4)];
        end
      end
    end
  end

endmodule

//--- verilog/aes_mix_add_key.sv
`timescale 1ns/100ps

module aes_mix_add_key import aes_pkg::*;
(
  input  aes_state_t  raw_state,
  input  aes_state_t  sub_state,
  input  aes_state_t  round_key,
  input  aes_mix_op_e mix_op,
  output aes_state_t  result
);

  aes_state_t mixed;
  aes_state_t picked;

  // MixColumns, one column at a time
  always_comb
  begin
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++)
    begin
      a0 = sub_state[0 * 4 + c];
      a1 = sub_state[1 * 4 + c];
      a2 = sub_state[2 * 4 + c];
      a3 = sub_state[3 * 4 + c];
      // 3*x written as xtime(x) ^ x
      mixed[0 * 4 + c] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      mixed[1 * 4 + c] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      mixed[2 * 4 + c] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      mixed[3 * 4 + c] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
  end

  // source select per operation
  always_comb
  begin
    case (mix_op)
      MIX_INIT:  picked = raw_state;
      MIX_FULL:  picked = mixed;
      MIX_FINAL: picked = sub_state;
      default:   picked = sub_state;
    endcase
  end

  // AddRoundKey
  assign result = picked ^ round_key;

endmodule

//--- verilog/aes_key_schedule.sv
`timescale 1ns/100ps

module aes_key_schedule import aes_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] key_in,
  input  logic       key_load,
  input  logic       block_start,
  input  logic       key_next,
  output aes_state_t round_key
);

  // cipher key as loaded, kept across blocks
  aes_state_t cipher_key;
  aes_state_t next_key;
  logic [3:0] slot;
  logic [7:0] rcon;
  // SubWord of the rotated last column
  logic [3:0][7:0] sub_word;

  // same row-major slot mapping as the state
  always_ff @(posedge clk)
  begin
    if (key_load)
      cipher_key[{slot[1:0], slot[3:2]}] <= key_in;
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      slot <= 4'd0;
    else if (block_start)
      slot <= 4'd0;
    else if (key_load)
      slot <= slot + 4'd1;
  end

  // RotWord feeds row r+1 of column 3 into row r
  for (genvar r = 0; r < 4; r++)
  begin : g_sub_word
    aes_sbox u_sbox
    (
      .a (round_key[((r + 1) % 4) * 4 + 3]),
      .s (sub_word[r])
    );
  end

  // word 0 takes the temp word, later words chain the xor
  always_comb
  begin
    for (int r = 0; r < 4; r++)
    begin
      next_key[r * 4] = round_key[r * 4] ^ sub_word[r] ^ ((r == 0) ? rcon : 8'h00);
      for (int c = 1; c < 4; c++)
      begin
        next_key[r * 4 + c] = round_key[r * 4 + c] ^ next_key[r * 4 + c - 1];
      end
    end
  end

  // start restores round key 0
  always_ff @(posedge clk)
  begin
    if (block_start)
      round_key <= cipher_key;
    else if (key_next)
      round_key <= next_key;
  end

  // rcon 01, 02, 04 ... 80, 1b, 36
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      rcon <= aes_rcon_first;
    else if (block_start)
      rcon <= aes_rcon_first;
    else if (key_next)
      rcon <= xtime(rcon);
  end

endmodule

//--- verilog/aes_enc_control.sv
`timescale 1ns/100ps

module aes_enc_control import aes_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        data_wr,
  input  logic        key_wr,
  input  logic        start,
  output logic        byte_load,
  output logic        key_load,
  output logic        block_start,
  output logic        shift_en,
  output logic        state_wr,
  output logic        key_next,
  output aes_mix_op_e mix_op,
  output logic        busy,
  output logic        done
);

  aes_fsm_e   fsm, fsm_next;
  // current round, 1 to 10
  logic [3:0] round;
  logic       last_round;

  assign busy       = (fsm != IDLE);
  assign last_round = (round == 4'(AES_ROUNDS));

  // writes and start are dropped while busy
  assign byte_load   = data_wr && !busy;
  assign key_load    = key_wr && !busy;
  assign block_start = start && !busy;

  // step strobes decoded from the state
  assign shift_en = (fsm == SHIFT);
  assign state_wr = (fsm == INIT_KEY) || (fsm == MIX);
  assign key_next = (fsm == INIT_KEY) || (fsm == MIX);
  assign done     = (fsm == FINISH);

  // initial add in INIT_KEY, no MixColumns in round 10
  always_comb
  begin
    mix_op = MIX_INIT;
    if (fsm == MIX)
      mix_op = last_round ? MIX_FINAL : MIX_FULL;
  end

  always_comb
  begin
    fsm_next = fsm;
    case (fsm)
      IDLE:
      begin
        if (block_start)
          fsm_next = INIT_KEY;
      end
      INIT_KEY:
        fsm_next = SHIFT;
      SHIFT:
        fsm_next = MIX;
      MIX:
      begin
        // two cycles per round until the last
        if (last_round)
          fsm_next = FINISH;
        else
          fsm_next = SHIFT;
      end
      FINISH:
        fsm_next = IDLE;
      default:
        fsm_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      fsm <= IDLE;
    else
      fsm <= fsm_next;
  end

  // round count advances on each write-back
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      round <= 4'd0;
    else if (block_start)
      round <= 4'd1;
    else if (fsm == MIX && !last_round)
      round <= round + 4'd1;
  end

endmodule

//--- verilog/aes_enc_top.sv
`timescale 1ns/100ps

module aes_enc_top import aes_pkg::*;
(
  input  logic                      clk,
  input  logic                      resetn,
  input  logic [7:0]                data_in,
  input  logic                      data_wr,
  input  logic [7:0]                key_in,
  input  logic                      key_wr,
  input  logic                      start,
  output logic                      busy,
  output logic                      done,
  output logic [AES_BLOCK_BITS-1:0] data_out
);

  logic        byte_load;
  logic        key_load;
  logic        block_start;
  logic        shift_en;
  logic        state_wr;
  logic        key_next;
  aes_mix_op_e mix_op;

  aes_state_t  state;
  aes_state_t  shift_out;
  aes_state_t  sub_state;
  aes_state_t  round_result;
  aes_state_t  round_key;

  aes_enc_control u_control
  (
    .clk         (clk),
    .resetn      (resetn),
    .data_wr     (data_wr),
    .key_wr      (key_wr),
    .start       (start),
    .byte_load   (byte_load),
    .key_load    (key_load),
    .block_start (block_start),
    .shift_en    (shift_en),
    .state_wr    (state_wr),
    .key_next    (key_next),
    .mix_op      (mix_op),
    .busy        (busy),
    .done        (done)
  );

  aes_enc_shifter u_shifter
  (
    .clk         (clk),
    .resetn      (resetn),
    .byte_in     (data_in),
    .byte_load   (byte_load),
    .block_start (block_start),
    .state_in    (round_result),
    .state_wr    (state_wr),
    .shift_en    (shift_en),
    .state       (state),
    .shift_out   (shift_out)
  );

  // SubBytes on the shifted state, order commutes with ShiftRows
  for (genvar i = 0; i < 16; i++)
  begin : g_sub_bytes
    aes_sbox u_sbox
    (
      .a (shift_out[i]),
      .s (sub_state[i])
    );
  end

  aes_mix_add_key u_mix_add_key
  (
    .raw_state (state),
    .sub_state (sub_state),
    .round_key (round_key),
    .mix_op    (mix_op),
    .result    (round_result)
  );

  aes_key_schedule u_key_schedule
  (
    .clk         (clk),
    .resetn      (resetn),
    .key_in      (key_in),
    .key_load    (key_load),
    .block_start (block_start),
    .key_next    (key_next),
    .round_key   (round_key)
  );

  // FIPS byte k sits at row k mod 4, col k div 4; byte 0 on top
  for (genvar k = 0; k < 16; k++)
  begin : g_data_out
    assign data_out[AES_BLOCK_BITS - 1 - 8 * k -: 8] = state[(k % 4) * 4 + k / 4];
  end

endmodule

//--- tb/aes_enc_sva.sv
`timescale 1ns/100ps

module aes_enc_sva import aes_pkg::*;
(
  input logic clk,
  input logic resetn,
  input logic start,
  input logic busy,
  input logic done
);

  // start edge, INIT_KEY, two cycles per round, FINISH
  localparam int DONE_LATENCY = 2 + 2 * AES_ROUNDS;

  // failed assertion count, read by the testbench summary
  int unsigned failures = 0;

  // single-cycle done
  done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
    else
    begin
      $error("done stayed high for more than one cycle");
      failures++;
    end

  // accepted start gives done at a fixed distance
  done_latency: assert property (@(posedge clk) disable iff (!resetn)
    (start && !busy) |-> ##DONE_LATENCY done)
    else
    begin
      $error("done did not follow start after the fixed latency");
      failures++;
    end

  // back to idle right after done
  idle_after_done: assert property (@(posedge clk) disable iff (!resetn) done |=> !busy)
    else
    begin
      $error("busy still high after done");
      failures++;
    end

  // reset holds the core idle
  reset_idle: assert property (@(posedge clk) !resetn |-> (!busy && !done))
    else
    begin
      $error("busy or done high during reset");
      failures++;
    end

  idle_after_reset: assert property (@(posedge clk) $rose(resetn) |-> !busy)
    else
    begin
      $error("busy high on the first cycle after reset");
      failures++;
    end

endmodule

bind aes_enc_top aes_enc_sva u_sva
(
  .clk    (clk),
  .resetn (resetn),
  .start  (start),
  .busy   (busy),
  .done   (done)
);

//--- tb/tb_aes_enc.sv
`timescale 1ns/100ps

module tb_aes_enc import aes_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS = 6;
  // per test, room for two full blocks with byte loading
  localparam int TEST_CYCLES = 100;
  // start edge, INIT_KEY, two cycles per round, FINISH
  localparam int DONE_LATENCY = 2 + 2 * AES_ROUNDS;
  localparam int DONE_TIMEOUT = 40;

  // FIPS-197 appendix C.1
  localparam logic [127:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  // FIPS-197 appendix B
  localparam logic [127:0] B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;

  logic                      clk;
  logic                      resetn;
  logic [7:0]                data_in;
  logic                      data_wr;
  logic [7:0]                key_in;
  logic                      key_wr;
  logic                      start;
  logic                      busy;
  logic                      done;
  logic [AES_BLOCK_BITS-1:0] data_out;

  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          failed_tests;
  logic [31:0] rng;

  aes_enc_top UUT
  (
    .clk      (clk),
    .resetn   (resetn),
    .data_in  (data_in),
    .data_wr  (data_wr),
    .key_in   (key_in),
    .key_wr   (key_wr),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .data_out (data_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog, whole run budget
  initial
  begin
    #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: the tests did not finish within their cycle budget");
    $display("TESTS FAILED");
    $finish;
  end

  // xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // stream byte k is bits 127-8k down, plaintext and optionally key
  task automatic load_block(input logic [127:0] key, input logic [127:0] pt, input bit with_key);
    for (int k = 0; k < 16; k++)
    begin
      @(posedge clk);
      data_in <= pt[127 - 8 * k -: 8];
      data_wr <= 1'b1;
      key_in  <= key[127 - 8 * k -: 8];
      key_wr  <= with_key;
    end
    @(posedge clk);
    data_wr <= 1'b0;
    key_wr  <= 1'b0;
  endtask

  // returns on the edge that samples start
  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // counts falling edges until done is seen
  task automatic wait_done(output int cycles);
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!done && cycles < DONE_TIMEOUT);
    if (!done)
    begin
      $display("error at %0t: done never rose within %0d cycles of start", $time, DONE_TIMEOUT);
      errors++;
    end
  endtask

  task automatic run_block(input logic [127:0] key, input logic [127:0] pt, input bit with_key,
                           input logic [127:0] exp);
    int cycles;
    load_block(key, pt, with_key);
    pulse_start();
    wait_done(cycles);
    compare("data_out", data_out, exp);
  endtask

  // junk on every input while the rounds run
  task automatic test_busy_writes();
    int cycles;
    load_block(B_KEY, B_PT, 1'b1);
    pulse_start();
    for (int i = 0; i < 15; i++)
    begin
      @(posedge clk);
      rng = xorshift32(rng);
      data_in <= rng[7:0];
      key_in  <= rng[15:8];
      data_wr <= rng[16];
      key_wr  <= rng[17];
      start   <= rng[18];
    end
    @(posedge clk);
    data_wr <= 1'b0;
    key_wr  <= 1'b0;
    start   <= 1'b0;
    wait_done(cycles);
    compare("data_out", data_out, B_CT);
    // slot counters must be back at 0
    run_block(C1_KEY, C1_PT, 1'b1, C1_CT);
  endtask

  task automatic test_reset_midway();
    load_block(C1_KEY, C1_PT, 1'b1);
    pulse_start();
    // round 5 shift step follows edge 9
    repeat (9) @(posedge clk);
    @(negedge clk);
    compare("busy", busy, 1'b1);
    @(posedge clk);
    resetn <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    compare("busy", busy, 1'b0);
    compare("done", done, 1'b0);
    compare("data_out", data_out, '0);
    @(posedge clk);
    resetn <= 1'b1;
    run_block(C1_KEY, C1_PT, 1'b1, C1_CT);
  endtask

  task automatic test_handshake();
    int          cycles;
    logic [127:0] held;
    load_block(B_KEY, B_PT, 1'b1);
    pulse_start();
    cycles = 0;
    // busy through every cycle up to and including done
    do
    begin
      @(negedge clk);
      cycles++;
      compare("busy", busy, 1'b1);
    end
    while (!done && cycles < DONE_TIMEOUT);
    compare("done latency", cycles, DONE_LATENCY);
    compare("data_out", data_out, B_CT);
    held = data_out;
    @(negedge clk);
    compare("done", done, 1'b0);
    compare("busy", busy, 1'b0);
    // idle, no writes, result must hold
    repeat (8)
    begin
      @(negedge clk);
      compare("data_out", data_out, held);
      compare("done", done, 1'b0);
    end
  endtask

  initial
  begin
    resetn  = 1'b0;
    data_in = 8'h00;
    data_wr = 1'b0;
    key_in  = 8'h00;
    key_wr  = 1'b0;
    start   = 1'b0;
    rng = 32'd77948;
    errors = 0;
    errors_at_start = 0;
    tests_run = 0;
    failed_tests = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);

    run_block(C1_KEY, C1_PT, 1'b1, C1_CT);
    finish_test("fips-197 c.1 vector");
    run_block(B_KEY, B_PT, 1'b1, B_CT);
    finish_test("fips-197 appendix b vector");
    // plaintext only, key comes from the stored cipher key
    run_block(B_KEY, B_PT, 1'b0, B_CT);
    finish_test("key retention");
    test_busy_writes();
    finish_test("writes while busy");
    test_reset_midway();
    finish_test("reset mid-encryption");
    test_handshake();
    finish_test("handshake levels");

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, failed_tests, errors, UUT.u_sva.failures);
    if (errors == 0 && UUT.u_sva.failures == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- compile.f
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_enc_shifter.sv
verilog/aes_mix_add_key.sv
verilog/aes_key_schedule.sv
verilog/aes_enc_control.sv
verilog/aes_enc_top.sv
tb/aes_enc_sva.sv
tb/tb_aes_enc.sv
